// File: mem_subsys.f
hw/mem_pkg.sv
hw/fetch_channel.sv
hw/data_channel.sv
hw/bus_arbiter.sv
hw/mem_subsys.sv
test/mem_subsys_assert.sv
test/mem_subsys_tb.sv

// File: test/mem_subsys_tb.sv
/* mem_subsys testbench with clock, reset, byte memory model, stimulus table,
   reference memory, bus ordering checks and a cycle limit */
`timescale 1ns/1ps

module mem_subsys_tb;

    localparam int N_ROWS = 52;

    logic clk_in = 1'b0;
    logic rst_n, rdy_in, io_buffer_full;
    logic fetch_en, fetch_wait, fetch_done;
    logic data_en, data_wr, data_wait, data_done, mem_wr;
    mem_pkg::addr_t fetch_addr, data_addr, mem_a;
    mem_pkg::word_t fetch_inst, data_wdata, data_rdata;
    mem_pkg::len_t  data_len;
    mem_pkg::byte_t mem_din, mem_dout;

    mem_pkg::byte_t mem [4096];
    mem_pkg::byte_t ref_mem [4096];
    mem_pkg::byte_t io_log [$];

    // stimulus table with one entry per row
    logic           row_data [N_ROWS];
    logic           row_wr [N_ROWS];
    mem_pkg::len_t  row_len [N_ROWS];
    mem_pkg::addr_t row_addr [N_ROWS];
    mem_pkg::word_t row_wdata [N_ROWS];
    int             row_delay [N_ROWS];
    logic           row_both [N_ROWS];
    int             row_io [N_ROWS];
    int             row_rdy [N_ROWS];

    int n_rows, err_count, cycle, limit, run_ch;
    logic [31:0] rng;
    mem_pkg::addr_t run_next;

    mem_subsys DUT (.*);

    always #2 clk_in = ~clk_in;

    // byte memory with one cycle read latency and logged I/O bytes
    always @(posedge clk_in) begin
        mem_din <= mem[mem_a[11:0]];
        if (mem_wr) begin
            if (mem_a[17:16] == mem_pkg::IO_SEL) begin
                io_log.push_back(mem_dout);
            end else begin
                mem[mem_a[11:0]] <= mem_dout;
            end
        end
    end

    // byte runs of one channel must be contiguous and never interleave
    always @(posedge clk_in) begin
        cycle++;
        if (cycle > limit) begin
            $display("timeout after %0d cycles, a done pulse never came", cycle);
            $display("SIMULATION FAILED");
            $finish;
        end
        if (rst_n && (DUT.u_arb.d_gnt || DUT.u_arb.f_gnt)) begin
            assert (run_ch == 0 || (run_ch == (DUT.u_arb.d_gnt ? 2 : 1) && mem_a == run_next))
            else begin
                $display("bus bytes out of order or interleaved at %0t, mem_a %h", $time, mem_a);
                err_count++;
            end
            if (DUT.u_arb.d_gnt) begin
                run_ch = DUT.u_arb.d_last ? 0 : 2;
            end else begin
                run_ch = DUT.u_arb.f_last ? 0 : 1;
            end
            run_next = mem_a + 1;
        end
        assert (!(mem_wr && io_buffer_full && mem_a[17:16] == mem_pkg::IO_SEL)) else begin
            $display("I/O write issued at %0t while the UART buffer was full", $time);
            err_count++;
        end
    end

    function automatic logic [31:0] next_rand();
        rng = rng ^ (rng << 13);
        rng = rng ^ (rng >> 17);
        rng = rng ^ (rng << 5);
        return rng;
    endfunction

    // low len bytes from the reference memory with zeros above
    function automatic mem_pkg::word_t expect_bytes(input mem_pkg::addr_t a, input int len);
        mem_pkg::word_t w;
        mem_pkg::addr_t b;
        w = '0;
        for (int j = 0; j < len; j++) begin
            b = a + j;
            w[j*8 +: 8] = ref_mem[b[11:0]];
        end
        return w;
    endfunction

    task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] got);
        assert (got === exp) else begin
            $display("CHECK FAILED t=%0t %s expected %h got %h", $time, name, exp, got);
            err_count++;
        end
    endtask

    task automatic add_row(input logic d, input logic w, input int len, input logic [31:0] a,
                           input logic [31:0] wd, input int dly, input logic both,
                           input int io, input int rdy);
        row_data[n_rows]  = d;
        row_wr[n_rows]    = d && w;
        row_len[n_rows]   = d ? len : 4;
        row_addr[n_rows]  = a;
        row_wdata[n_rows] = wd;
        row_delay[n_rows] = dly;
        row_both[n_rows]  = both;
        row_io[n_rows]    = io;
        row_rdy[n_rows]   = rdy;
        n_rows++;
    endtask

    task automatic run_row(input int i);
        int k;
        int f_at;
        int d_at;
        logic want_f;
        logic want_d;
        mem_pkg::word_t f_val;
        mem_pkg::word_t d_val;
        mem_pkg::addr_t f_a;
        mem_pkg::addr_t b;
        want_d = row_data[i];
        want_f = !row_data[i] || row_both[i];
        f_a = row_data[i] ? row_addr[i] + 32'h80 : row_addr[i];
        f_at = -1;
        d_at = -1;
        repeat (row_delay[i]) @(negedge clk_in);
        @(negedge clk_in);
        fetch_en = want_f;
        fetch_addr = f_a;
        data_en = want_d;
        data_wr = row_wr[i];
        data_len = row_len[i];
        data_addr = row_addr[i];
        data_wdata = row_wdata[i];
        io_buffer_full = (row_io[i] > 0);
        @(posedge clk_in);
        assert (!fetch_wait && !data_wait) else begin
            $display("row %0d was offered while a channel was still busy", i);
            err_count++;
        end
        k = 0;
        while ((want_f && f_at < 0) || (want_d && d_at < 0)) begin
            @(negedge clk_in);
            fetch_en = 1'b0;
            data_en = 1'b0;
            io_buffer_full = (k + 1 < row_io[i]);
            // frozen cycles start in the second cycle of the transaction
            rdy_in = !((k + 1 >= 2) && (k + 1 <= 1 + row_rdy[i]));
            @(posedge clk_in);
            k++;
            // a channel stays busy up to and including its done cycle
            if (want_f && f_at < 0) begin
                check_val("fetch_wait", 1, fetch_wait);
            end
            if (want_d && d_at < 0) begin
                check_val("data_wait", 1, data_wait);
            end
            if (fetch_done) begin
                f_at = k;
                f_val = fetch_inst;
            end
            if (data_done) begin
                d_at = k;
                d_val = data_rdata;
            end
        end
        if (want_d && row_wr[i]) begin
            check_val("data_rdata", '0, d_val);
            for (int j = 0; j < row_len[i]; j++) begin
                b = row_addr[i] + j;
                if (b[17:16] == mem_pkg::IO_SEL) begin
                    assert (io_log.size() > 0) else begin
                        $display("I/O store byte %0d of row %0d never reached the bus", j, i);
                        err_count++;
                    end
                    if (io_log.size() > 0) begin
                        check_val("mem_dout", row_wdata[i][j*8 +: 8], io_log.pop_front());
                    end
                end else begin
                    ref_mem[b[11:0]] = row_wdata[i][j*8 +: 8];
                end
            end
        end else if (want_d) begin
            check_val("data_rdata", expect_bytes(row_addr[i], row_len[i]), d_val);
        end
        if (want_d && !row_both[i] && row_io[i] == 0) begin
            check_val("data_done latency", row_len[i] + 1 + row_rdy[i], d_at);
        end
        if (want_f) begin
            check_val("fetch_inst", expect_bytes(f_a, 4), f_val);
        end
        if (!row_data[i]) begin
            check_val("fetch_done latency", 5 + row_rdy[i], f_at);
        end else if (want_f) begin
            assert (d_at < f_at) else begin
                $display("row %0d fetch finished before its data transaction", i);
                err_count++;
            end
        end
    endtask

    initial begin
        logic [31:0] x;
        int len;
        rst_n = 1'b0;
        rdy_in = 1'b1;
        io_buffer_full = 1'b0;
        fetch_en = 1'b0;
        fetch_addr = '0;
        data_en = 1'b0;
        data_wr = 1'b0;
        data_len = 3'd1;
        data_addr = '0;
        data_wdata = '0;
        mem_din = '0;
        err_count = 0;
        cycle = 0;
        n_rows = 0;
        run_ch = 0;
        run_next = '0;
        limit = 1000;
        rng = 32'd2510;
        for (int a = 0; a < 4096; a++) begin
            mem[a] = next_rand() ^ a;
            ref_mem[a] = mem[a];
        end
        // data, wr, len, addr, wdata, delay, both, io cycles, rdy low cycles
        add_row(0, 0, 4, 32'h100, 0, 2, 0, 0, 0);
        add_row(1, 1, 1, 32'h200, 32'h000000A5, 1, 0, 0, 0);
        add_row(1, 0, 1, 32'h200, 0, 0, 0, 0, 0);
        add_row(1, 1, 2, 32'h210, 32'h0000BEEF, 0, 0, 0, 0);
        add_row(1, 0, 2, 32'h210, 0, 1, 0, 0, 0);
        add_row(1, 1, 4, 32'h220, 32'h12345678, 0, 0, 0, 0);
        add_row(1, 0, 4, 32'h220, 0, 0, 0, 0, 0);
        add_row(1, 0, 4, 32'h220, 0, 2, 1, 0, 0);
        add_row(1, 1, 2, 32'h230, 32'h0000CAFE, 0, 1, 0, 0);
        add_row(1, 1, 1, 32'h30000, 32'h0000005A, 1, 0, 5, 0);
        add_row(0, 0, 4, 32'h104, 0, 0, 0, 0, 3);
        add_row(1, 0, 4, 32'h220, 0, 0, 0, 0, 2);
        for (int r = 0; r < 40; r++) begin
            x = next_rand();
            len = (x[1:0] == 2'd0) ? 1 : ((x[1:0] == 2'd1) ? 2 : 4);
            add_row(x[2], x[3], len, {20'd0, x[31:20]}, next_rand(), int'(x[17:16]),
                    x[2] && (x[19:18] == 2'd0), 0, x[9] ? int'(x[8]) + 1 : 0);
        end
        limit = 0;
        for (int r = 0; r < n_rows; r++) begin
            limit += row_delay[r] + 6 + row_io[r] + row_rdy[r];
        end
        limit = limit * 2 + 100;
        repeat (8) @(negedge clk_in);
        rst_n = 1'b1;
        for (int r = 0; r < n_rows; r++) begin
            run_row(r);
        end
        $display("rows run %0d, errors %0d", n_rows, err_count);
        if (err_count == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

// File: test/mem_subsys_assert.sv
/* concurrent checks on the request handshake, bus ownership, done pulses
   and frozen cycles, bound into mem_subsys */
`timescale 1ns/1ps

module mem_subsys_assert (
    input logic            clk_in,
    input logic            rst_n,
    input logic            rdy_in,
    input logic            fetch_en,
    input logic            fetch_wait,
    input logic            fetch_done,
    input logic            data_en,
    input logic            data_wait,
    input logic            data_done,
    input logic            mem_wr,
    input logic            f_gnt,
    input logic            f_last,
    input mem_pkg::owner_t owner
);

    // a busy channel takes no new request
    a_fetch_busy: assert property (@(posedge clk_in) disable iff (!rst_n)
        fetch_wait |-> !fetch_en) else $error("fetch request while fetch_wait high");
    a_data_busy: assert property (@(posedge clk_in) disable iff (!rst_n)
        data_wait |-> !data_en) else $error("data request while data_wait high");

    // fetch keeps the bus locked after every byte but its last
    a_fetch_no_wr: assert property (@(posedge clk_in) disable iff (!rst_n)
        f_gnt && !f_last |=> owner == mem_pkg::OWN_FETCH && !mem_wr)
        else $error("mem_wr under fetch ownership");

    a_fetch_pulse: assert property (@(posedge clk_in) disable iff (!rst_n)
        fetch_done |=> !fetch_done) else $error("fetch_done longer than one cycle");
    a_data_pulse: assert property (@(posedge clk_in) disable iff (!rst_n)
        data_done |=> !data_done) else $error("data_done longer than one cycle");

    // frozen cycle
    a_frozen_state: assert property (@(posedge clk_in) disable iff (!rst_n)
        !rdy_in |=> $stable(owner) && $stable(fetch_wait) && $stable(data_wait))
        else $error("state changed while frozen");

endmodule

bind mem_subsys mem_subsys_assert u_assert (
    .clk_in     (clk_in),
    .rst_n      (rst_n),
    .rdy_in     (rdy_in),
    .fetch_en   (fetch_en),
    .fetch_wait (fetch_wait),
    .fetch_done (fetch_done),
    .data_en    (data_en),
    .data_wait  (data_wait),
    .data_done  (data_done),
    .mem_wr     (mem_wr),
    .f_gnt      (f_gnt),
    .f_last     (f_last),
    .owner      (u_arb.owner)
);

// File: hw/mem_subsys.sv
/* mem_subsys: fetch channel, data channel and bus arbiter on the byte-wide
   memory bus */
`timescale 1ns/1ps

module mem_subsys (
    input  logic            clk_in,
    input  logic            rst_n,
    input  logic            rdy_in,
    // instruction fetch port
    input  logic            fetch_en,
    input  mem_pkg::addr_t  fetch_addr,
    output logic            fetch_wait,
    output logic            fetch_done,
    output mem_pkg::word_t  fetch_inst,
    // load and store port
    input  logic            data_en,
    input  logic            data_wr,
    input  mem_pkg::len_t   data_len,
    input  mem_pkg::addr_t  data_addr,
    input  mem_pkg::word_t  data_wdata,
    output logic            data_wait,
    output logic            data_done,
    output mem_pkg::word_t  data_rdata,
    input  logic            io_buffer_full,
    // external memory bus
    input  mem_pkg::byte_t  mem_din,
    output mem_pkg::byte_t  mem_dout,
    output mem_pkg::addr_t  mem_a,
    output logic            mem_wr
);

    logic           f_req;
    logic           f_last;
    mem_pkg::addr_t f_addr;
    logic           f_gnt;
    logic           f_rvalid;
    logic           d_req;
    logic           d_wr;
    logic           d_last;
    mem_pkg::addr_t d_addr;
    mem_pkg::byte_t d_wdata;
    logic           d_gnt;
    logic           d_rvalid;
    mem_pkg::byte_t rdata;

    fetch_channel u_fetch (
        .clk_in   (clk_in),
        .rst_n    (rst_n),
        .rdy_in   (rdy_in),
        .en       (fetch_en),
        .addr     (fetch_addr),
        .busy     (fetch_wait),
        .done     (fetch_done),
        .inst     (fetch_inst),
        .req      (f_req),
        .last     (f_last),
        .req_addr (f_addr),
        .gnt      (f_gnt),
        .rvalid   (f_rvalid),
        .rdata    (rdata)
    );

    data_channel u_data (
        .clk_in         (clk_in),
        .rst_n          (rst_n),
        .rdy_in         (rdy_in),
        .en             (data_en),
        .wr             (data_wr),
        .len            (data_len),
        .addr           (data_addr),
        .wdata          (data_wdata),
        .io_buffer_full (io_buffer_full),
        .busy           (data_wait),
        .done           (data_done),
        .rdata_word     (data_rdata),
        .req            (d_req),
        .req_wr         (d_wr),
        .last           (d_last),
        .req_addr       (d_addr),
        .req_wdata      (d_wdata),
        .gnt            (d_gnt),
        .rvalid         (d_rvalid),
        .rdata          (rdata)
    );

    bus_arbiter u_arb (
        .clk_in   (clk_in),
        .rst_n    (rst_n),
        .rdy_in   (rdy_in),
        .f_req    (f_req),
        .f_last   (f_last),
        .f_addr   (f_addr),
        .f_gnt    (f_gnt),
        .f_rvalid (f_rvalid),
        .d_req    (d_req),
        .d_wr     (d_wr),
        .d_last   (d_last),
        .d_addr   (d_addr),
        .d_wdata  (d_wdata),
        .d_gnt    (d_gnt),
        .d_rvalid (d_rvalid),
        .rdata    (rdata),
        .mem_din  (mem_din),
        .mem_a    (mem_a),
        .mem_dout (mem_dout),
        .mem_wr   (mem_wr)
    );

endmodule

// File: hw/bus_arbiter.sv
/* bus_arbiter: per-transaction lock of the byte memory bus, data channel
   priority, read return routing */
`timescale 1ns/1ps

module bus_arbiter (
    input  logic            clk_in,
    input  logic            rst_n,
    input  logic            rdy_in,
    input  logic            f_req,
    input  logic            f_last,
    input  mem_pkg::addr_t  f_addr,
    output logic            f_gnt,
    output logic            f_rvalid,
    input  logic            d_req,
    input  logic            d_wr,
    input  logic            d_last,
    input  mem_pkg::addr_t  d_addr,
    input  mem_pkg::byte_t  d_wdata,
    output logic            d_gnt,
    output logic            d_rvalid,
    output mem_pkg::byte_t  rdata,
    input  mem_pkg::byte_t  mem_din,
    output mem_pkg::addr_t  mem_a,
    output mem_pkg::byte_t  mem_dout,
    output logic            mem_wr
);

    mem_pkg::owner_t owner;
    mem_pkg::owner_t rd_tag;
    mem_pkg::addr_t  hold_a;

    // no grant in a frozen cycle, so nothing reaches memory then
    assign d_gnt = rdy_in && d_req &&
                   ((owner == mem_pkg::OWN_DATA) || (owner == mem_pkg::OWN_NONE));
    assign f_gnt = rdy_in && f_req &&
                   ((owner == mem_pkg::OWN_FETCH) || ((owner == mem_pkg::OWN_NONE) && !d_req));

    // idle bus keeps the last address, so a pending read byte stays on mem_din
    assign mem_a    = d_gnt ? d_addr : (f_gnt ? f_addr : hold_a);
    assign mem_dout = d_gnt ? d_wdata : '0;
    assign mem_wr   = d_gnt && d_wr;

    // memory answers one cycle after the read
    assign rdata    = mem_din;
    assign f_rvalid = (rd_tag == mem_pkg::OWN_FETCH);
    assign d_rvalid = (rd_tag == mem_pkg::OWN_DATA);

    always_ff @(posedge clk_in or negedge rst_n) begin
        if (!rst_n) begin
            owner  <= mem_pkg::OWN_NONE;
            rd_tag <= mem_pkg::OWN_NONE;
            hold_a <= '0;
        end else if (rdy_in) begin
            // lock held until the last byte goes out
            if (d_gnt) begin
                owner  <= d_last ? mem_pkg::OWN_NONE : mem_pkg::OWN_DATA;
                hold_a <= d_addr;
            end else if (f_gnt) begin
                owner  <= f_last ? mem_pkg::OWN_NONE : mem_pkg::OWN_FETCH;
                hold_a <= f_addr;
            end

            if (d_gnt && !d_wr) begin
                rd_tag <= mem_pkg::OWN_DATA;
            end else if (f_gnt) begin
                rd_tag <= mem_pkg::OWN_FETCH;
            end else begin
                rd_tag <= mem_pkg::OWN_NONE;
            end
        end
    end

endmodule

// File: hw/data_channel.sv
/* data_channel: one outstanding load or store of 1, 2 or 4 bytes, with
   the I/O write stall on a full UART buffer */
`timescale 1ns/1ps

module data_channel (
    input  logic            clk_in,
    input  logic            rst_n,
    input  logic            rdy_in,
    input  logic            en,
    input  logic            wr,
    input  mem_pkg::len_t   len,
    input  mem_pkg::addr_t  addr,
    input  mem_pkg::word_t  wdata,
    input  logic            io_buffer_full,
    output logic            busy,
    output logic            done,
    output mem_pkg::word_t  rdata_word,
    output logic            req,
    output logic            req_wr,
    output logic            last,
    output mem_pkg::addr_t  req_addr,
    output mem_pkg::byte_t  req_wdata,
    input  logic            gnt,
    input  logic            rvalid,
    input  mem_pkg::byte_t  rdata
);

    mem_pkg::chan_state_t state;
    mem_pkg::byte_idx_t   issue_idx;
    mem_pkg::byte_idx_t   rcv_idx;
    logic                 wr_q;
    mem_pkg::len_t        len_q;
    mem_pkg::addr_t       base;
    mem_pkg::word_t       wdata_q;
    mem_pkg::word_t       load_buf;
    mem_pkg::word_t       merged;
    logic                 accept;
    logic                 io_stall;

    assign accept = rdy_in && en && (state == mem_pkg::CH_IDLE);
    assign busy   = (state != mem_pkg::CH_IDLE);

    assign req_addr  = base + mem_pkg::addr_t'(issue_idx);
    assign req_wdata = wdata_q[issue_idx*8 +: 8];
    assign req_wr    = wr_q;
    assign last      = ({1'b0, issue_idx} == len_q - 3'd1);

    // UART output cannot take a byte while its buffer is full
    assign io_stall = wr_q && io_buffer_full &&
                      (req_addr[mem_pkg::IO_SEL_HI:mem_pkg::IO_SEL_LO] == mem_pkg::IO_SEL);
    assign req = (state == mem_pkg::CH_ISSUE) && !io_stall;

    // a store is complete after its last write, a load on its last byte
    assign done = rdy_in && (state == mem_pkg::CH_DRAIN) && (wr_q || rvalid);

    // last load byte is merged straight from the bus in the done cycle
    always_comb begin
        merged = load_buf;
        if (rvalid) begin
            merged[rcv_idx*8 +: 8] = rdata;
        end
    end

    assign rdata_word = wr_q ? '0 : merged;

    always_ff @(posedge clk_in or negedge rst_n) begin
        if (!rst_n) begin
            state     <= mem_pkg::CH_IDLE;
            issue_idx <= '0;
            rcv_idx   <= '0;
        end else if (rdy_in) begin
            case (state)
                mem_pkg::CH_IDLE: begin
                    if (en) begin
                        state     <= mem_pkg::CH_ISSUE;
                        issue_idx <= '0;
                        rcv_idx   <= '0;
                    end
                end
                mem_pkg::CH_ISSUE: begin
                    if (gnt) begin
                        issue_idx <= issue_idx + 2'd1;
                        if (last) begin
                            state <= mem_pkg::CH_DRAIN;
                        end
                    end
                end
                mem_pkg::CH_DRAIN: begin
                    if (wr_q || rvalid) begin
                        state <= mem_pkg::CH_IDLE;
                    end
                end
                default: state <= mem_pkg::CH_IDLE;
            endcase
            if (rvalid) begin
                rcv_idx <= rcv_idx + 2'd1;
            end
        end
    end

    // request fields, and the load word cleared so unused bytes read as zero
    always_ff @(posedge clk_in) begin
        if (accept) begin
            wr_q     <= wr;
            len_q    <= len;
            base     <= addr;
            wdata_q  <= wdata;
            load_buf <= '0;
        end else if (rdy_in && rvalid) begin
            load_buf[rcv_idx*8 +: 8] <= rdata;
        end
    end

endmodule

// File: hw/fetch_channel.sv
/* fetch_channel: one outstanding instruction fetch, four byte reads
   assembled into a little-endian word */
`timescale 1ns/1ps

module fetch_channel (
    input  logic            clk_in,
    input  logic            rst_n,
    input  logic            rdy_in,
    input  logic            en,
    input  mem_pkg::addr_t  addr,
    output logic            busy,
    output logic            done,
    output mem_pkg::word_t  inst,
    output logic            req,
    output logic            last,
    output mem_pkg::addr_t  req_addr,
    input  logic            gnt,
    input  logic            rvalid,
    input  mem_pkg::byte_t  rdata
);

    mem_pkg::chan_state_t state;
    mem_pkg::byte_idx_t   issue_idx;
    mem_pkg::byte_idx_t   rcv_idx;
    mem_pkg::addr_t       base;
    logic [23:0]          low_bytes;
    logic                 accept;

    assign accept = rdy_in && en && (state == mem_pkg::CH_IDLE);
    assign busy   = (state != mem_pkg::CH_IDLE);

    // one byte read per granted cycle, ascending addresses
    assign req      = (state == mem_pkg::CH_ISSUE);
    assign req_addr = base + mem_pkg::addr_t'(issue_idx);
    assign last     = ({1'b0, issue_idx} == mem_pkg::FETCH_LEN - 3'd1);

    // byte 3 is the only read still in flight once in CH_DRAIN
    assign done = rdy_in && rvalid && (state == mem_pkg::CH_DRAIN);
    assign inst = {rdata, low_bytes};

    always_ff @(posedge clk_in or negedge rst_n) begin
        if (!rst_n) begin
            state     <= mem_pkg::CH_IDLE;
            issue_idx <= '0;
            rcv_idx   <= '0;
        end else if (rdy_in) begin
            case (state)
                mem_pkg::CH_IDLE: begin
                    if (en) begin
                        state     <= mem_pkg::CH_ISSUE;
                        issue_idx <= '0;
                        rcv_idx   <= '0;
                    end
                end
                mem_pkg::CH_ISSUE: begin
                    if (gnt) begin
                        issue_idx <= issue_idx + 2'd1;
                        if (last) begin
                            state <= mem_pkg::CH_DRAIN;
                        end
                    end
                end
                mem_pkg::CH_DRAIN: begin
                    if (rvalid) begin
                        state <= mem_pkg::CH_IDLE;
                    end
                end
                default: state <= mem_pkg::CH_IDLE;
            endcase
            // returned bytes arrive in issue order
            if (rvalid) begin
                rcv_idx <= rcv_idx + 2'd1;
            end
        end
    end

    // request address and the first three returned bytes
    always_ff @(posedge clk_in) begin
        if (accept) begin
            base <= addr;
        end
        if (rdy_in && rvalid && (state == mem_pkg::CH_ISSUE)) begin
            low_bytes[rcv_idx*8 +: 8] <= rdata;
        end
    end

endmodule

// File: hw/mem_pkg.sv
/* shared widths, address constants, payload typedefs and the channel and
   bus owner enums of the memory subsystem */
package mem_pkg;

    // basic widths
    localparam int ADDR_W = 32;
    localparam int WORD_W = 32;
    localparam int BYTE_W = 8;
    localparam int LEN_W  = 3;
    localparam int IDX_W  = 2;

    // byte address, only 17:0 reach the memory
    typedef logic [ADDR_W-1:0] addr_t;

    // instruction or data word
    typedef logic [WORD_W-1:0] word_t;

    // one byte of the external bus
    typedef logic [BYTE_W-1:0] byte_t;

    // access length in bytes, 1, 2 or 4
    typedef logic [LEN_W-1:0] len_t;

    // byte position inside one transaction
    typedef logic [IDX_W-1:0] byte_idx_t;

    // I/O space is marked by address bits 17:16
    localparam int IO_SEL_HI = 17;
    localparam int IO_SEL_LO = 16;
    localparam logic [1:0] IO_SEL = 2'd3;

    // every fetch reads a whole instruction
    localparam len_t FETCH_LEN = 3'd4;

    // per channel FSM
    typedef enum logic [1:0] {
        CH_IDLE,
        CH_ISSUE,
        CH_DRAIN
    } chan_state_t;

    // who holds the memory bus
    typedef enum logic [1:0] {
        OWN_NONE,
        OWN_FETCH,
        OWN_DATA
    } owner_t;

endpackage
